// ==== files.f ====
+incdir+logic
logic/hdr_pkg.sv
logic/tx_word_fifo.sv
logic/crc5_byte_engine.sv
logic/ddr_word_framer.sv
logic/ddr_pair_serializer.sv
logic/hdr_ddr_tx.sv
testbench/tb_hdr_ddr_tx.sv

// ==== logic/crc5_byte_engine.sv ====
`timescale 1ns/1ps
`include "hdr_config.svh"

module crc5_byte_engine (
  input  logic                  i_sys_clk,
  input  logic                  i_sys_rst,
  input  logic [7:0]            i_parallel_data,
  input  logic                  i_input_valid,  // One strobe per byte
  input  logic                  i_enable,       // High for the whole frame
  output logic [`HDR_CRC_W-1:0] o_crc_value,
  output logic                  o_crc_valid
);

  typedef enum logic {
    IDLE     = 1'b0,
    CALC_CRC = 1'b1
  } crc_state_t;

  crc_state_t            state_q;
  crc_state_t            state_nxt;
  logic [`HDR_CRC_W-1:0] crc_q;

  // Eight serial LFSR steps unrolled into one clock
  // MSB of the byte enters first, feedback is crc MSB xor data bit
  function automatic logic [`HDR_CRC_W-1:0] fold_byte(
    input logic [`HDR_CRC_W-1:0] crc_in,
    input logic [7:0]            data
  );
    logic [`HDR_CRC_W-1:0] crc;
    logic                  fb;
    crc = crc_in;
    for (int i = 7; i >= 0; i--) begin
      fb  = crc[`HDR_CRC_W-1] ^ data[i];
      crc = {crc[`HDR_CRC_W-2:0], 1'b0};  // Shift towards x^5
      if (fb) begin
        crc = crc ^ `HDR_CRC_POLY;        // Apply x^2 + 1 taps
      end
    end
    return crc;
  endfunction

  // IDLE waits for a byte, CALC_CRC is the cycle the folded value is out
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      IDLE:     if (i_input_valid) state_nxt = CALC_CRC;
      CALC_CRC: state_nxt = i_input_valid ? CALC_CRC : IDLE;  // Back-to-back bytes stay
      default:  state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q <= IDLE;
      crc_q   <= `HDR_CRC_INIT;
    end else if (!i_enable) begin
      state_q <= IDLE;
      crc_q   <= `HDR_CRC_INIT;     // Reseed between frames
    end else begin
      state_q <= state_nxt;
      if (i_input_valid) begin
        crc_q <= fold_byte(crc_q, i_parallel_data);
      end
    end
  end

  assign o_crc_value = crc_q;                  // No final inversion
  assign o_crc_valid = (state_q == CALC_CRC);  // One cycle after each byte

endmodule

// ==== logic/ddr_pair_serializer.sv ====
`timescale 1ns/1ps
`include "hdr_config.svh"

module ddr_pair_serializer (
  input  logic                  i_sys_clk,
  input  logic                  i_sys_rst,
  input  logic                  i_load,       // Only while o_busy is low
  input  hdr_pkg::hdr_tx_word_t i_word,
  input  logic                  i_frame_end,  // Loaded word is the CRC word
  output logic [1:0]            o_sda_pair,   // Bit 1 goes on the line first
  output logic                  o_pair_valid,
  output logic                  o_busy,
  output logic                  o_frame_done
);

  logic [`HDR_WORD_W-1:0]     shift_q;  // Line bits, MSB next out
  logic [`HDR_PAIR_CNT_W-1:0] cnt_q;    // Pairs still to send

  // Shift register, no reset needed on the payload
  always_ff @(posedge i_sys_clk) begin
    if (i_load) begin
      shift_q <= i_word.bits;
    end else if (cnt_q != '0) begin
      shift_q <= {shift_q[`HDR_WORD_W-3:0], 2'b00};  // Two bits per clock
    end
  end

  // Pair counter is the only control state
  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      cnt_q <= '0;
    end else if (i_load) begin
      cnt_q <= i_word.pairs;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // One pair per rising edge of the system clock, one bit per SCL edge
  assign o_sda_pair   = shift_q[`HDR_WORD_W-1 -: 2];
  assign o_pair_valid = (cnt_q != '0);  // Contiguous for the whole word
  assign o_busy       = (cnt_q != '0);

  // Final pair of the CRC word closes the frame
  assign o_frame_done = i_frame_end && (cnt_q == `HDR_PAIR_CNT_W'(1));

endmodule

// ==== logic/ddr_word_framer.sv ====
`timescale 1ns/1ps
`include "hdr_config.svh"

module ddr_word_framer (
  input  logic                  i_sys_clk,
  input  logic                  i_sys_rst,
  input  hdr_pkg::hdr_wdata_t   i_fifo_data,   // Show-ahead head of buffer
  input  logic                  i_fifo_empty,
  input  logic                  i_ser_busy,
  input  logic [`HDR_CRC_W-1:0] i_crc_value,
  output logic                  o_fifo_rd,
  output logic                  o_crc_enable,
  output logic [7:0]            o_crc_byte,
  output logic                  o_crc_strobe,
  output logic                  o_ser_load,
  output hdr_pkg::hdr_tx_word_t o_ser_word,
  output logic                  o_frame_end    // Serializer holds the CRC word
);
  import hdr_pkg::*;

  localparam int CRC_WORD_LEN = 2 + 4 + `HDR_CRC_W + 1;  // Preamble, token, CRC, setup

  typedef enum logic [2:0] {
    IDLE,
    POP,
    LOAD,
    WAIT_CRC,
    SEND_CRC,
    CLOSE
  } frm_state_t;

  frm_state_t state_q;
  frm_state_t state_nxt;
  hdr_wdata_t word_q;      // Popped word, payload only
  logic       lo_byte_q;   // Low byte goes to CRC this cycle
  logic       crc_word_q;  // CRC word sits in the serializer
  logic [1:0] parity;      // {PA1, PA0}
  logic       close_done;

  // PA1 over odd bits, PA0 over even bits then inverted
  function automatic logic [1:0] ddr_parity(input logic [`HDR_DATA_W-1:0] d);
    logic pa1;
    logic pa0;
    pa1 = 1'b0;
    pa0 = 1'b0;
    for (int i = 0; i < `HDR_DATA_W; i++) begin
      if (i % 2 == 1) begin
        pa1 = pa1 ^ d[i];
      end else begin
        pa0 = pa0 ^ d[i];
      end
    end
    return {pa1, ~pa0};
  endfunction

  assign parity     = ddr_parity(word_q.data);
  assign close_done = (state_q == CLOSE) && !i_ser_busy;  // Last pair has gone out

  // Frame sequencing
  always_comb begin
    state_nxt = state_q;
    case (state_q)
      IDLE:     if (!i_fifo_empty) state_nxt = POP;               // Frame opens
      POP:      if (o_fifo_rd) state_nxt = LOAD;
      LOAD:     state_nxt = word_q.last ? WAIT_CRC : POP;
      WAIT_CRC: if (!i_ser_busy && !lo_byte_q) state_nxt = SEND_CRC;
      SEND_CRC: state_nxt = CLOSE;
      CLOSE:    if (!i_ser_busy) state_nxt = IDLE;
      default:  state_nxt = IDLE;
    endcase
  end

  // Pop only when the serializer can take the word right after
  assign o_fifo_rd = (state_q == POP) && !i_fifo_empty && !i_ser_busy;

  // Hold the popped word until the next pop
  always_ff @(posedge i_sys_clk) begin
    if (o_fifo_rd) begin
      word_q <= i_fifo_data;
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q    <= IDLE;
      lo_byte_q  <= 1'b0;
      crc_word_q <= 1'b0;
    end else begin
      state_q   <= state_nxt;
      lo_byte_q <= (state_q == LOAD);  // Low byte follows high byte
      if (state_q == SEND_CRC) begin
        crc_word_q <= 1'b1;
      end else if (close_done) begin
        crc_word_q <= 1'b0;
      end
    end
  end

  // CRC engine feed, high byte in LOAD, low byte the cycle after
  assign o_crc_enable = (state_q != IDLE) && !close_done;
  assign o_crc_strobe = (state_q == LOAD) || lo_byte_q;
  assign o_crc_byte   = lo_byte_q ? word_q.data[7:0] : word_q.data[`HDR_DATA_W-1 -: 8];

  // Serializer side
  assign o_ser_load  = (state_q == LOAD) || (state_q == SEND_CRC);
  assign o_frame_end = crc_word_q;

  always_comb begin
    if (state_q == SEND_CRC) begin
      // CRC has settled, both bytes of the last word are in
      o_ser_word.bits  = {2'b01, `HDR_CRC_TOKEN, i_crc_value, 1'b1,
                          {(`HDR_WORD_W - CRC_WORD_LEN){1'b0}}};
      o_ser_word.pairs = `HDR_CRC_PAIRS;
    end else begin
      o_ser_word.bits  = {2'b10, word_q.data, parity};  // Data preamble 10
      o_ser_word.pairs = `HDR_DATA_PAIRS;
    end
  end

endmodule

// ==== logic/hdr_config.svh ====
`ifndef HDR_CONFIG_SVH
`define HDR_CONFIG_SVH

// Data path sizes
`define HDR_DATA_W      16       // Payload bits per data word
`define HDR_FIFO_DEPTH  8        // Write buffer entries
`define HDR_FIFO_AW     3        // Pointer width, log2 of depth

// Line framing
`define HDR_WORD_W      20       // Preamble + data + parity
`define HDR_PAIR_CNT_W  4        // Enough for 10 pairs
`define HDR_DATA_PAIRS  4'd10    // 20 bits, two per clock
`define HDR_CRC_PAIRS   4'd6     // 12-bit CRC word

// CRC-5 word, x^5 + x^2 + 1
`define HDR_CRC_W       5
`define HDR_CRC_POLY    5'b00101 // Taps below x^5
`define HDR_CRC_INIT    5'b11111 // Seed at frame start
`define HDR_CRC_TOKEN   4'b1100  // Marks the CRC word

`endif

// ==== logic/hdr_ddr_tx.sv ====
`timescale 1ns/1ps
`include "hdr_config.svh"

module hdr_ddr_tx (
  input  logic                i_sys_clk,
  input  logic                i_sys_rst,
  input  logic                i_wr_valid,    // One-cycle write strobe
  input  hdr_pkg::hdr_wdata_t i_wr_data,
  output logic                o_fifo_full,   // Writes are dropped while high
  output logic [1:0]          o_sda_pair,
  output logic                o_pair_valid,
  output logic                o_frame_done
);
  import hdr_pkg::*;

  hdr_wdata_t            fifo_rd_data;
  logic                  fifo_empty;
  logic                  fifo_rd;
  logic                  crc_enable;
  logic [7:0]            crc_byte;
  logic                  crc_strobe;
  logic [`HDR_CRC_W-1:0] crc_value;
  logic                  ser_load;
  hdr_tx_word_t          ser_word;
  logic                  ser_busy;
  logic                  frame_end;

  // Write buffer
  tx_word_fifo u_fifo (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .i_wr_en   (i_wr_valid),
    .i_wr_data (i_wr_data),
    .i_rd_en   (fifo_rd),
    .o_rd_data (fifo_rd_data),
    .o_empty   (fifo_empty),
    .o_full    (o_fifo_full)
  );

  // Frame control
  ddr_word_framer u_framer (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_fifo_data  (fifo_rd_data),
    .i_fifo_empty (fifo_empty),
    .i_ser_busy   (ser_busy),
    .i_crc_value  (crc_value),
    .o_fifo_rd    (fifo_rd),
    .o_crc_enable (crc_enable),
    .o_crc_byte   (crc_byte),
    .o_crc_strobe (crc_strobe),
    .o_ser_load   (ser_load),
    .o_ser_word   (ser_word),
    .o_frame_end  (frame_end)
  );

  // Running CRC over the data bytes; framer reads the value, not the valid flag
  crc5_byte_engine u_crc (
    .i_sys_clk       (i_sys_clk),
    .i_sys_rst       (i_sys_rst),
    .i_parallel_data (crc_byte),
    .i_input_valid   (crc_strobe),
    .i_enable        (crc_enable),
    .o_crc_value     (crc_value),
    .o_crc_valid     ()
  );

  // Line side
  ddr_pair_serializer u_ser (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_load       (ser_load),
    .i_word       (ser_word),
    .i_frame_end  (frame_end),
    .o_sda_pair   (o_sda_pair),
    .o_pair_valid (o_pair_valid),
    .o_busy       (ser_busy),
    .o_frame_done (o_frame_done)
  );

endmodule

// ==== logic/hdr_pkg.sv ====
`include "hdr_config.svh"

package hdr_pkg;

  // One entry of the write buffer
  // last marks the final word of a frame, CRC word follows it
  typedef struct packed {
    logic [`HDR_DATA_W-1:0] data;  // Sent high byte first
    logic                   last;  // End of frame
  } hdr_wdata_t;

  // One unit of work for the serializer
  // Data word:  {2'b10, data[15:0], pa1, pa0}
  // CRC word:   {2'b01, token, crc[4:0], 1'b1}, left aligned, low bits zero
  typedef struct packed {
    logic [`HDR_WORD_W-1:0]     bits;   // MSB goes out first
    logic [`HDR_PAIR_CNT_W-1:0] pairs;  // Number of bit pairs to shift out
  } hdr_tx_word_t;

endpackage

// ==== logic/tx_word_fifo.sv ====
`timescale 1ns/1ps
`include "hdr_config.svh"

module tx_word_fifo (
  input  logic                i_sys_clk,
  input  logic                i_sys_rst,
  input  logic                i_wr_en,
  input  hdr_pkg::hdr_wdata_t i_wr_data,
  input  logic                i_rd_en,
  output hdr_pkg::hdr_wdata_t o_rd_data,
  output logic                o_empty,
  output logic                o_full
);
  import hdr_pkg::*;

  localparam logic [`HDR_FIFO_AW:0] FULL_CNT = `HDR_FIFO_DEPTH;

  hdr_wdata_t                mem [0:`HDR_FIFO_DEPTH-1]; // Storage, no reset
  logic [`HDR_FIFO_AW-1:0]   wr_ptr_q;
  logic [`HDR_FIFO_AW-1:0]   rd_ptr_q;
  logic [`HDR_FIFO_AW:0]     count_q;    // One extra bit to tell full from empty
  logic                      wr_ok;
  logic                      rd_ok;

  // Qualified strobes
  assign wr_ok = i_wr_en && !o_full;   // Write into a full buffer is lost
  assign rd_ok = i_rd_en && !o_empty;  // Guard against underflow

  // Status levels
  assign o_empty = (count_q == '0);
  assign o_full  = (count_q == FULL_CNT);

  // Show-ahead, head entry is always on the output
  assign o_rd_data = mem[rd_ptr_q];

  // Payload write
  always_ff @(posedge i_sys_clk) begin
    if (wr_ok) begin
      mem[wr_ptr_q] <= i_wr_data;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;  // Word consumed in the pop cycle
      end
    end
  end

  // Occupancy
  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      count_q <= '0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither, level unchanged
      endcase
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the HDR-DDR transmit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f --top-module tb_hdr_ddr_tx -o sim_tb \
  > sim.log 2>&1 && ./obj_dir/sim_tb >> sim.log 2>&1 || echo "build or run returned an error" >> sim.log

# The log decides the result
grep -qx "all tests passed" sim.log && echo "PASS, see sim.log" && exit 0 \
  || { echo "FAIL, see sim.log"; exit 1; }

// ==== testbench/tb_hdr_ddr_tx.sv ====
`timescale 1ns/1ps
`include "hdr_config.svh"

module tb_hdr_ddr_tx;
  import hdr_pkg::*;

  // The head word leaves for the framer before a burst fills the buffer
  localparam int BURST_ACCEPTED = `HDR_FIFO_DEPTH + 1;
  // Line pairs per test in order of single, five words, two frames, burst plus tail, gaps
  localparam int STREAM_PAIRS   = 16 + 56 + 2 * 36 + ((BURST_ACCEPTED + 1) * 10 + 6) + 66;
  localparam int SLACK_CYCLES   = 31 * 2 + 6 * 10 + 6 * 8 + 8 + 6 * 4; // Pop, frame ends, gaps
  localparam int TIMEOUT_CYCLES = (STREAM_PAIRS + SLACK_CYCLES) * 2;

  logic         i_sys_clk;
  logic         i_sys_rst;
  logic         i_wr_valid;
  hdr_wdata_t   i_wr_data;
  logic         o_fifo_full;
  logic [1:0]   o_sda_pair;
  logic         o_pair_valid;
  logic         o_frame_done;

  logic [2:0]   exp_q [$];   // Entries of {frame done, pair} in line order
  logic [4:0]   model_crc;   // Running CRC of the open frame
  logic [31:0]  seed;
  string        test_name;
  int           cycle_cnt;

  hdr_ddr_tx DUT (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_wr_valid   (i_wr_valid),
    .i_wr_data    (i_wr_data),
    .o_fifo_full  (o_fifo_full),
    .o_sda_pair   (o_sda_pair),
    .o_pair_valid (o_pair_valid),
    .o_frame_done (o_frame_done)
  );

  initial begin
    i_sys_clk = 1'b0;
    forever #50 i_sys_clk = ~i_sys_clk;  // 100 ns period
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  // LCG with the constants of the classic C library generator
  function automatic logic [31:0] next_random();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic logic [15:0] random_word();
    logic [31:0] r;
    r = next_random();
    return r[31:16];  // Upper bits have the longer period
  endfunction

  function automatic int random_gap();
    logic [31:0] r;
    r = next_random();
    return int'(r[31:29]);  // 0 to 7 idle cycles
  endfunction

  // PA1 over odd bits, PA0 over even bits inverted
  function automatic logic [1:0] ref_parity(input logic [15:0] d);
    return {^(d & 16'hAAAA), ~^(d & 16'h5555)};
  endfunction

  // Serial CRC-5 over x^5 + x^2 + 1 with the MSB first
  function automatic logic [4:0] ref_crc_byte(input logic [4:0] crc_in, input logic [7:0] b);
    logic [4:0] c;
    logic       fb;
    c = crc_in;
    for (int k = 7; k >= 0; k--) begin
      fb = c[4] ^ b[k];
      c  = {c[3], c[2], c[1] ^ fb, c[0], fb};  // Feedback into x^2 and x^0
    end
    return c;
  endfunction

  // Expected line pairs of one accepted word and the CRC word behind a last word
  task automatic model_word(input logic [15:0] data, input logic last);
    logic [19:0] dw;
    logic [11:0] cw;
    dw = {2'b10, data, ref_parity(data)};
    for (int i = 9; i >= 0; i--) begin
      exp_q.push_back({1'b0, dw[2*i+1 -: 2]});  // Earlier bit in bit 1
    end
    model_crc = ref_crc_byte(model_crc, data[15:8]);  // High byte first
    model_crc = ref_crc_byte(model_crc, data[7:0]);
    if (last) begin
      cw = {2'b01, `HDR_CRC_TOKEN, model_crc, 1'b1};
      for (int i = 5; i >= 0; i--) begin
        exp_q.push_back({(i == 0), cw[2*i+1 -: 2]});  // Done on the final pair
      end
      model_crc = `HDR_CRC_INIT;  // Next frame starts fresh
    end
  endtask

  // Drives one write and queues its pairs unless the buffer should be full
  // The next call or idle_cycles ends the strobe
  task automatic write_word(input logic [15:0] data, input logic last, input logic exp_full);
    hdr_wdata_t w;
    w.data = data;
    w.last = last;
    @(posedge i_sys_clk);
    i_wr_valid <= 1'b1;
    i_wr_data  <= w;
    @(negedge i_sys_clk);
    assert (o_fifo_full == exp_full) else
      fail_now($sformatf("mismatch %s fifo_full expected %b actual %b",
                         test_name, exp_full, o_fifo_full));
    if (!exp_full) begin
      model_word(data, last);  // Captured by the next edge
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge i_sys_clk);
      i_wr_valid <= 1'b0;
    end
  endtask

  task automatic wait_stream_drained();
    while (exp_q.size() != 0) @(negedge i_sys_clk);  // Timeout guards this
    idle_cycles(4);  // Any extra pair is flagged by the monitor
  endtask

  // Pair checker sampled mid-cycle
  always @(negedge i_sys_clk) begin
    logic [2:0] exp_pair;
    if (i_sys_rst) begin
      if (o_pair_valid) begin
        if (exp_q.size() == 0) begin
          fail_now($sformatf("pair %b on the line in test %s with none expected",
                             o_sda_pair, test_name));
        end else begin
          exp_pair = exp_q.pop_front();
          assert (o_sda_pair == exp_pair[1:0]) else
            fail_now($sformatf("mismatch %s pair expected %b actual %b",
                               test_name, exp_pair[1:0], o_sda_pair));
          assert (o_frame_done == exp_pair[2]) else
            fail_now($sformatf("mismatch %s frame_done expected %b actual %b",
                               test_name, exp_pair[2], o_frame_done));
        end
      end else begin
        assert (!o_frame_done) else fail_now("frame done pulsed in a cycle without a pair");
      end
    end
  end

  // Run limit
  always @(posedge i_sys_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_now($sformatf("timeout in test %s, %0d pairs still expected",
                         test_name, exp_q.size()));
    end
  end

  initial begin
    seed       = 32'd56385;
    model_crc  = `HDR_CRC_INIT;
    cycle_cnt  = 0;
    test_name  = "reset";
    i_sys_rst  = 1'b0;
    i_wr_valid = 1'b0;
    i_wr_data  = '0;
    repeat (4) @(posedge i_sys_clk);
    i_sys_rst <= 1'b1;

    // Quiet line until the first write
    repeat (8) begin
      @(negedge i_sys_clk);
      assert (!o_pair_valid && !o_frame_done && !o_fifo_full) else
        fail_now("outputs not idle after reset");
    end

    test_name = "single_word";
    write_word(random_word(), 1'b1, 1'b0);
    idle_cycles(1);
    wait_stream_drained();

    test_name = "five_words";
    for (int i = 0; i < 5; i++) write_word(random_word(), (i == 4), 1'b0);
    idle_cycles(1);
    wait_stream_drained();

    test_name = "two_frames";  // Both CRCs from init
    for (int i = 0; i < 6; i++) write_word(random_word(), (i == 2) || (i == 5), 1'b0);
    idle_cycles(1);
    wait_stream_drained();

    test_name = "back_pressure";
    for (int i = 0; i < 12; i++) write_word(random_word(), 1'b0, (i >= BURST_ACCEPTED));
    idle_cycles(1);
    @(negedge i_sys_clk);
    while (o_fifo_full) @(negedge i_sys_clk);  // Next pop frees an entry
    write_word(random_word(), 1'b1, 1'b0);  // Closes the frame
    idle_cycles(1);
    wait_stream_drained();

    test_name = "random_gaps";
    for (int i = 0; i < 6; i++) begin
      write_word(random_word(), (i == 5), 1'b0);
      idle_cycles(random_gap());
    end
    idle_cycles(1);
    wait_stream_drained();

    $display("all tests passed");
    $finish;
  end

endmodule
